// ==== logic/lc3b_isa_pkg.sv ====
`default_nettype none

package lc3b_isa_pkg;

    // Machine word, also the width of every address
    typedef logic [15:0] lc3b_word;

    // Register number for R0 to R7
    typedef logic [2:0] lc3b_reg;

    // Opcode field, instruction bits 15 to 12
    typedef enum logic [3:0] {
        OP_BR   = 4'b0000,
        OP_ADD  = 4'b0001,
        OP_LDB  = 4'b0010,
        OP_STB  = 4'b0011,
        OP_JSR  = 4'b0100,
        OP_AND  = 4'b0101,
        OP_LDR  = 4'b0110,
        OP_STR  = 4'b0111,
        OP_RTI  = 4'b1000,
        OP_NOT  = 4'b1001,
        OP_LDI  = 4'b1010,
        OP_STI  = 4'b1011,
        OP_JMP  = 4'b1100,
        OP_SHF  = 4'b1101,
        OP_LEA  = 4'b1110,
        OP_TRAP = 4'b1111
    } lc3b_opcode;

endpackage : lc3b_isa_pkg

`default_nettype wire

// ==== logic/lc3b_ctrl_pkg.sv ====
`default_nettype none

package lc3b_ctrl_pkg;

    // Operation the execute stage will carry out
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_AND  = 3'b001,
        ALU_NOT  = 3'b010,
        ALU_PASS = 3'b011,
        ALU_SHF  = 3'b100
    } lc3b_aluop;

    // Decoded control bits carried down the pipeline, 12 bits in all
    typedef struct packed {
        lc3b_isa_pkg::lc3b_opcode opcode;
        lc3b_aluop                aluop;
        logic                     load_regfile;
        logic                     mem_read;
        logic                     mem_write;
        logic                     branch;
        // Instruction bit 5, immediate form of ADD and AND
        logic                     imm_sel;
    } lc3b_control_word;

endpackage : lc3b_ctrl_pkg

`default_nettype wire

// ==== logic/fetch_bundle_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// One fetched instruction on its way from fetch into the IF/ID latch
interface fetch_bundle_if;

    lc3b_isa_pkg::lc3b_word           instr;
    lc3b_isa_pkg::lc3b_word           pc_in;
    lc3b_isa_pkg::lc3b_word           offset6;
    lc3b_isa_pkg::lc3b_word           offset9;
    lc3b_isa_pkg::lc3b_word           offset11;
    lc3b_ctrl_pkg::lc3b_control_word  ctrl_word;

    modport source
    (
        output instr,
        output pc_in,
        output offset6,
        output offset9,
        output offset11
    );

    modport rom
    (
        input  instr,
        output ctrl_word
    );

    modport sink
    (
        input instr,
        input pc_in,
        input offset6,
        input offset9,
        input offset11,
        input ctrl_word
    );

endinterface : fetch_bundle_if

`default_nettype wire

// ==== logic/frontend_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module frontend_control
(
    input  logic clk,
    input  logic reset,
    input  logic imem_resp,
    input  logic stall,
    input  logic redirect,
    output logic imem_read,
    output logic advance,
    output logic load_hold,
    output logic flush
);

    typedef enum logic [1:0] {
        IDLE_ISSUE,
        WAIT_RESP,
        HELD,
        DROP
    } state_t;

    state_t state;
    state_t state_next;

    // First read goes out straight after reset
    always_ff @(posedge clk)
    begin
        if (reset)
            state <= WAIT_RESP;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            // One idle cycle while the new PC settles
            IDLE_ISSUE:
                state_next = WAIT_RESP;
            WAIT_RESP:
            begin
                if (redirect)
                    state_next = imem_resp ? IDLE_ISSUE : DROP;
                else if (imem_resp)
                    state_next = stall ? HELD : IDLE_ISSUE;
            end
            HELD:
            begin
                if (redirect || !stall)
                    state_next = IDLE_ISSUE;
            end
            // Stale read still in memory, swallow its response
            DROP:
            begin
                if (imem_resp)
                    state_next = IDLE_ISSUE;
            end
            default:
                state_next = WAIT_RESP;
        endcase
    end

    assign imem_read = (state == WAIT_RESP) || (state == DROP);
    assign advance   = !redirect && !stall
                       && (((state == WAIT_RESP) && imem_resp) || (state == HELD));
    assign load_hold = !redirect && stall && (state == WAIT_RESP) && imem_resp;
    assign flush     = redirect;

endmodule : frontend_control

`default_nettype wire

// ==== logic/fetch_pc.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_pc
#(
    parameter lc3b_isa_pkg::lc3b_word RESET_PC = 16'h0000
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  lc3b_isa_pkg::lc3b_word imem_rdata,
    input  logic                   advance,
    input  logic                   load_hold,
    input  logic                   redirect,
    input  lc3b_isa_pkg::lc3b_word redirect_pc,
    output lc3b_isa_pkg::lc3b_word imem_addr,
    fetch_bundle_if.source         bundle
);

    lc3b_isa_pkg::lc3b_word pc_reg;
    lc3b_isa_pkg::lc3b_word hold_word;
    lc3b_isa_pkg::lc3b_word cur_instr;
    logic                   hold_valid;

    // Redirect wins over a normal step
    always_ff @(posedge clk)
    begin
        if (reset)
            pc_reg <= RESET_PC;
        else if (redirect)
            pc_reg <= redirect_pc;
        else if (advance)
            pc_reg <= pc_reg + 16'd2;
    end

    always_ff @(posedge clk)
    begin
        if (reset || redirect || advance)
            hold_valid <= 1'b0;
        else if (load_hold)
            hold_valid <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (load_hold)
            hold_word <= imem_rdata;
    end

    // Live memory data unless a word arrived during a stall
    assign cur_instr = hold_valid ? hold_word : imem_rdata;
    assign imem_addr = pc_reg;

    assign bundle.instr    = cur_instr;
    assign bundle.pc_in    = pc_reg;
    assign bundle.offset6  = {{10{cur_instr[5]}}, cur_instr[5:0]};
    assign bundle.offset9  = {{6{cur_instr[8]}}, cur_instr[8:0], 1'b0};
    assign bundle.offset11 = {{4{cur_instr[10]}}, cur_instr[10:0], 1'b0};

endmodule : fetch_pc

`default_nettype wire

// ==== logic/control_rom.sv ====
`timescale 1ns/100ps
`default_nettype none

module control_rom
(
    fetch_bundle_if.rom bundle
);

    lc3b_ctrl_pkg::lc3b_control_word ctrl;
    lc3b_isa_pkg::lc3b_opcode        opcode;

    assign opcode = lc3b_isa_pkg::lc3b_opcode'(bundle.instr[15:12]);

    always_comb
    begin
        ctrl              = '0;
        ctrl.opcode       = opcode;
        ctrl.aluop        = lc3b_ctrl_pkg::ALU_ADD;
        case (opcode)
            lc3b_isa_pkg::OP_ADD:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.imm_sel      = bundle.instr[5];
            end
            lc3b_isa_pkg::OP_AND:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.aluop        = lc3b_ctrl_pkg::ALU_AND;
                ctrl.imm_sel      = bundle.instr[5];
            end
            lc3b_isa_pkg::OP_NOT:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.aluop        = lc3b_ctrl_pkg::ALU_NOT;
            end
            lc3b_isa_pkg::OP_SHF:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.aluop        = lc3b_ctrl_pkg::ALU_SHF;
            end
            // Loads compute an address with add, then write a register
            lc3b_isa_pkg::OP_LDB,
            lc3b_isa_pkg::OP_LDI,
            lc3b_isa_pkg::OP_LDR:
            begin
                ctrl.mem_read     = 1'b1;
                ctrl.load_regfile = 1'b1;
            end
            lc3b_isa_pkg::OP_STB,
            lc3b_isa_pkg::OP_STI,
            lc3b_isa_pkg::OP_STR:
                ctrl.mem_write = 1'b1;
            lc3b_isa_pkg::OP_BR,
            lc3b_isa_pkg::OP_JMP,
            lc3b_isa_pkg::OP_JSR,
            lc3b_isa_pkg::OP_TRAP:
                ctrl.branch = 1'b1;
            lc3b_isa_pkg::OP_LEA:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.aluop        = lc3b_ctrl_pkg::ALU_PASS;
            end
            // RTI decodes to no control activity
            default:
                ctrl.branch = 1'b0;
        endcase
    end

    assign bundle.ctrl_word = ctrl;

endmodule : control_rom

`default_nettype wire

// ==== logic/ifid_latch.sv ====
`timescale 1ns/100ps
`default_nettype none

module ifid_latch
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            advance,
    input  logic                            flush,
    fetch_bundle_if.sink                    bundle,
    output lc3b_isa_pkg::lc3b_reg           dest,
    output lc3b_isa_pkg::lc3b_reg           src1,
    output lc3b_isa_pkg::lc3b_reg           src2,
    output lc3b_isa_pkg::lc3b_word          imm5,
    output lc3b_isa_pkg::lc3b_word          imm4,
    output lc3b_isa_pkg::lc3b_word          trapvect8,
    output lc3b_isa_pkg::lc3b_word          offset6_out,
    output lc3b_isa_pkg::lc3b_word          offset9_out,
    output lc3b_isa_pkg::lc3b_word          offset11_out,
    output lc3b_isa_pkg::lc3b_word          pc,
    output lc3b_ctrl_pkg::lc3b_control_word ctrl_word_out,
    output logic                            ready
);

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            ready         <= 1'b0;
            ctrl_word_out <= '0;
        end
        else if (advance)
        begin
            ready <= 1'b1;
            // All-zero word is a NOP, not a never-taken branch
            if (bundle.instr == 16'd0)
                ctrl_word_out <= '0;
            else
                ctrl_word_out <= bundle.ctrl_word;
        end
    end

    // Field registers only move on advance
    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            dest         <= bundle.instr[11:9];
            src1         <= bundle.instr[8:6];
            src2         <= bundle.instr[2:0];
            imm5         <= {{11{bundle.instr[4]}}, bundle.instr[4:0]};
            imm4         <= {12'd0, bundle.instr[3:0]};
            trapvect8    <= {7'd0, bundle.instr[7:0], 1'b0};
            offset6_out  <= bundle.offset6;
            offset9_out  <= bundle.offset9;
            offset11_out <= bundle.offset11;
            pc           <= bundle.pc_in + 16'd2;
        end
    end

endmodule : ifid_latch

`default_nettype wire

// ==== logic/lc3b_frontend.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc3b_frontend
#(
    parameter lc3b_isa_pkg::lc3b_word RESET_PC = 16'h0000
)
(
    input  logic                            clk,
    input  logic                            reset,
    output logic                            imem_read,
    output lc3b_isa_pkg::lc3b_word          imem_addr,
    input  lc3b_isa_pkg::lc3b_word          imem_rdata,
    input  logic                            imem_resp,
    input  logic                            stall,
    input  logic                            redirect,
    input  lc3b_isa_pkg::lc3b_word          redirect_pc,
    output lc3b_isa_pkg::lc3b_reg           dest,
    output lc3b_isa_pkg::lc3b_reg           src1,
    output lc3b_isa_pkg::lc3b_reg           src2,
    output lc3b_isa_pkg::lc3b_word          imm5,
    output lc3b_isa_pkg::lc3b_word          imm4,
    output lc3b_isa_pkg::lc3b_word          trapvect8,
    output lc3b_isa_pkg::lc3b_word          offset6,
    output lc3b_isa_pkg::lc3b_word          offset9,
    output lc3b_isa_pkg::lc3b_word          offset11,
    output lc3b_isa_pkg::lc3b_word          pc,
    output lc3b_ctrl_pkg::lc3b_control_word ctrl_word,
    output logic                            decode_valid
);

    logic advance;
    logic load_hold;
    logic flush;

    fetch_bundle_if bundle ();

    frontend_control u_control
    (
        .clk       (clk),
        .reset     (reset),
        .imem_resp (imem_resp),
        .stall     (stall),
        .redirect  (redirect),
        .imem_read (imem_read),
        .advance   (advance),
        .load_hold (load_hold),
        .flush     (flush)
    );

    fetch_pc #(.RESET_PC(RESET_PC)) u_fetch_pc
    (
        .clk         (clk),
        .reset       (reset),
        .imem_rdata  (imem_rdata),
        .advance     (advance),
        .load_hold   (load_hold),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .bundle      (bundle.source)
    );

    control_rom u_control_rom
    (
        .bundle (bundle.rom)
    );

    ifid_latch u_ifid
    (
        .clk           (clk),
        .reset         (reset),
        .advance       (advance),
        .flush         (flush),
        .bundle        (bundle.sink),
        .dest          (dest),
        .src1          (src1),
        .src2          (src2),
        .imm5          (imm5),
        .imm4          (imm4),
        .trapvect8     (trapvect8),
        .offset6_out   (offset6),
        .offset9_out   (offset9),
        .offset11_out  (offset11),
        .pc            (pc),
        .ctrl_word_out (ctrl_word),
        .ready         (decode_valid)
    );

endmodule : lc3b_frontend

`default_nettype wire

// ==== verification/imem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

// Instruction memory with a random fill and a random response delay
module imem_model
#(
    parameter int SEED = 80269
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   read,
    input  lc3b_isa_pkg::lc3b_word addr,
    output lc3b_isa_pkg::lc3b_word rdata,
    output logic                   resp,
    output logic                   req_start
);

    lc3b_isa_pkg::lc3b_word mem [64];
    lc3b_isa_pkg::lc3b_word req_addr;
    logic [16:0]            lfsr_state;
    logic [1:0]             count;
    logic                   busy;

    // Fibonacci LFSR x^17 + x^14 + 1 stepped once per bit
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr_state[16] ^ lfsr_state[13];
            lfsr_state = {lfsr_state[15:0], fb};
            bits = {bits[14:0], fb};
        end
        return bits;
    endfunction

    assign req_start = read && !busy && !resp;

    always @(posedge clk)
    begin
        if (reset)
        begin
            lfsr_state = 17'(SEED);
            for (int i = 0; i < 64; i++)
            begin
                mem[i] = take_bits(16);
                // Every eighth word is a zero instruction
                if (i % 8 == 5)
                    mem[i] = 16'd0;
            end
            busy  <= 1'b0;
            resp  <= 1'b0;
            rdata <= 16'd0;
            count <= 2'd0;
        end
        else if (resp)
        begin
            resp  <= 1'b0;
            busy  <= 1'b0;
            // Data is valid only in the response cycle
            rdata <= ~rdata;
        end
        else if (req_start)
        begin
            busy     <= 1'b1;
            req_addr <= addr;
            count    <= 2'(take_bits(2));
        end
        else if (busy)
        begin
            if (count == 2'd0)
            begin
                resp  <= 1'b1;
                rdata <= mem[req_addr[6:1]];
            end
            else
                count <= count - 2'd1;
        end
    end

endmodule : imem_model

`default_nettype wire

// ==== verification/tb_lc3b_frontend.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_lc3b_frontend;

    localparam lc3b_isa_pkg::lc3b_word RESET_PC = 16'h0020;
    localparam int NUM_INSTR = 200;
    localparam int CYCLE_LIMIT = 4 * NUM_INSTR * (3 + 4);

    logic                            clk;
    logic                            reset;
    logic                            imem_read;
    lc3b_isa_pkg::lc3b_word          imem_addr;
    lc3b_isa_pkg::lc3b_word          imem_rdata;
    logic                            imem_resp;
    logic                            req_start;
    logic                            stall;
    logic                            redirect;
    lc3b_isa_pkg::lc3b_word          redirect_pc;
    lc3b_isa_pkg::lc3b_reg           dest;
    lc3b_isa_pkg::lc3b_reg           src1;
    lc3b_isa_pkg::lc3b_reg           src2;
    lc3b_isa_pkg::lc3b_word          imm5;
    lc3b_isa_pkg::lc3b_word          imm4;
    lc3b_isa_pkg::lc3b_word          trapvect8;
    lc3b_isa_pkg::lc3b_word          offset6;
    lc3b_isa_pkg::lc3b_word          offset9;
    lc3b_isa_pkg::lc3b_word          offset11;
    lc3b_isa_pkg::lc3b_word          pc;
    lc3b_ctrl_pkg::lc3b_control_word ctrl_word;
    logic                            decode_valid;

    // Reference state of the expected latch contents and the next fetch address
    logic                            exp_valid;
    lc3b_isa_pkg::lc3b_word          exp_instr;
    lc3b_isa_pkg::lc3b_word          exp_addr;
    lc3b_ctrl_pkg::lc3b_control_word exp_ctrl;
    lc3b_isa_pkg::lc3b_word          exp_fetch;
    lc3b_isa_pkg::lc3b_word          flight_addr;
    logic                            flight_stale;
    logic                            pend_valid;
    lc3b_isa_pkg::lc3b_word          pend_word;
    lc3b_isa_pkg::lc3b_word          pend_addr;
    logic                            have_word;
    lc3b_isa_pkg::lc3b_word          cur_word;
    lc3b_isa_pkg::lc3b_word          cur_addr;
    int                              delivered;
    int                              zeros_seen;
    int                              redirects_seen;
    int                              cycles;
    logic [16:0]                     lfsr_state;

    lc3b_frontend #(.RESET_PC(RESET_PC)) dut
    (
        .clk          (clk),
        .reset        (reset),
        .imem_read    (imem_read),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .imem_resp    (imem_resp),
        .stall        (stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .dest         (dest),
        .src1         (src1),
        .src2         (src2),
        .imm5         (imm5),
        .imm4         (imm4),
        .trapvect8    (trapvect8),
        .offset6      (offset6),
        .offset9      (offset9),
        .offset11     (offset11),
        .pc           (pc),
        .ctrl_word    (ctrl_word),
        .decode_valid (decode_valid)
    );

    imem_model #(.SEED(80269)) u_imem
    (
        .clk       (clk),
        .reset     (reset),
        .read      (imem_read),
        .addr      (imem_addr),
        .rdata     (imem_rdata),
        .resp      (imem_resp),
        .req_start (req_start)
    );

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr_state[16] ^ lfsr_state[13];
            lfsr_state = {lfsr_state[15:0], fb};
            bits = {bits[14:0], fb};
        end
        return bits;
    endfunction

    // Control word table of the ISA with the zero word as a NOP
    function automatic lc3b_ctrl_pkg::lc3b_control_word ref_ctrl(
        input lc3b_isa_pkg::lc3b_word w
    );
        lc3b_ctrl_pkg::lc3b_control_word c;
        c = '0;
        if (w != 16'd0)
        begin
            c.opcode = lc3b_isa_pkg::lc3b_opcode'(w[15:12]);
            c.aluop  = lc3b_ctrl_pkg::ALU_ADD;
            case (w[15:12])
                4'b0001:
                begin
                    c.load_regfile = 1'b1;
                    c.imm_sel      = w[5];
                end
                4'b0101:
                begin
                    c.load_regfile = 1'b1;
                    c.aluop        = lc3b_ctrl_pkg::ALU_AND;
                    c.imm_sel      = w[5];
                end
                4'b1001:
                begin
                    c.load_regfile = 1'b1;
                    c.aluop        = lc3b_ctrl_pkg::ALU_NOT;
                end
                4'b1101:
                begin
                    c.load_regfile = 1'b1;
                    c.aluop        = lc3b_ctrl_pkg::ALU_SHF;
                end
                4'b0010, 4'b0110, 4'b1010:
                begin
                    c.load_regfile = 1'b1;
                    c.mem_read     = 1'b1;
                end
                4'b0011, 4'b0111, 4'b1011:
                    c.mem_write = 1'b1;
                4'b0000, 4'b0100, 4'b1100, 4'b1111:
                    c.branch = 1'b1;
                4'b1110:
                begin
                    c.load_regfile = 1'b1;
                    c.aluop        = lc3b_ctrl_pkg::ALU_PASS;
                end
                default:
                    c.branch = 1'b0;
            endcase
        end
        return c;
    endfunction

    task automatic value_error(input string name, input logic [15:0] got,
                               input logic [15:0] want);
        $display("error at %0t: %s is %h, expected %h", $time, name, got, want);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic run_failure(input string what);
        $display("%s at %0t", what, $time);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reference model follows the memory traffic and the upstream controls
    always @(posedge clk)
    begin
        have_word = 1'b0;
        cur_word  = pend_word;
        cur_addr  = pend_addr;
        if (reset)
        begin
            exp_valid    <= 1'b0;
            exp_ctrl     <= '0;
            exp_fetch    <= RESET_PC;
            flight_stale <= 1'b0;
            pend_valid   <= 1'b0;
        end
        else
        begin
            if (req_start)
            begin
                flight_addr  <= imem_addr;
                flight_stale <= redirect;
            end
            else if (redirect)
                flight_stale <= 1'b1;
            if (redirect)
            begin
                exp_valid  <= 1'b0;
                exp_ctrl   <= '0;
                pend_valid <= 1'b0;
                exp_fetch  <= redirect_pc;
            end
            else
            begin
                if (imem_resp && !flight_stale)
                begin
                    have_word = 1'b1;
                    cur_word  = imem_rdata;
                    cur_addr  = flight_addr;
                end
                else if (pend_valid)
                    have_word = 1'b1;
                if (have_word && stall)
                begin
                    pend_valid <= 1'b1;
                    pend_word  <= cur_word;
                    pend_addr  <= cur_addr;
                end
                else if (have_word)
                begin
                    exp_valid  <= 1'b1;
                    exp_instr  <= cur_word;
                    exp_addr   <= cur_addr;
                    exp_ctrl   <= ref_ctrl(cur_word);
                    pend_valid <= 1'b0;
                    exp_fetch  <= exp_fetch + 16'd2;
                    delivered  <= delivered + 1;
                    if (cur_word == 16'd0)
                        zeros_seen <= zeros_seen + 1;
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT)
            run_failure("timeout, the decoder stopped delivering instructions");
    end

    a_reset_state: assert property (@(posedge clk) $fell(reset) |->
        imem_read && imem_addr == RESET_PC && !decode_valid && ctrl_word == '0)
        else run_failure("outputs after reset are not in the reset state");

    a_fetch_addr: assert property (@(posedge clk) disable iff (reset)
        req_start |-> imem_addr == exp_fetch)
        else value_error("imem_addr", $sampled(imem_addr), $sampled(exp_fetch));

    a_valid: assert property (@(posedge clk) disable iff (reset)
        decode_valid == exp_valid)
        else value_error("decode_valid", 16'($sampled(decode_valid)),
                         16'($sampled(exp_valid)));

    a_ctrl: assert property (@(posedge clk) disable iff (reset)
        ctrl_word == exp_ctrl)
        else value_error("ctrl_word", 16'($sampled(ctrl_word)), 16'($sampled(exp_ctrl)));

    a_pc: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> pc == exp_addr + 16'd2)
        else value_error("pc", $sampled(pc), $sampled(exp_addr) + 16'd2);

    a_dest: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> dest == exp_instr[11:9])
        else value_error("dest", 16'($sampled(dest)), 16'($sampled(exp_instr[11:9])));

    a_src1: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> src1 == exp_instr[8:6])
        else value_error("src1", 16'($sampled(src1)), 16'($sampled(exp_instr[8:6])));

    a_src2: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> src2 == exp_instr[2:0])
        else value_error("src2", 16'($sampled(src2)), 16'($sampled(exp_instr[2:0])));

    a_imm5: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> imm5 == 16'($signed(exp_instr[4:0])))
        else value_error("imm5", $sampled(imm5), 16'($signed($sampled(exp_instr[4:0]))));

    a_imm4: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> imm4 == 16'(exp_instr[3:0]))
        else value_error("imm4", $sampled(imm4), 16'($sampled(exp_instr[3:0])));

    a_trapvect8: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> trapvect8 == 16'(exp_instr[7:0]) * 16'd2)
        else value_error("trapvect8", $sampled(trapvect8),
                         16'($sampled(exp_instr[7:0])) * 16'd2);

    a_offset6: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> offset6 == 16'($signed(exp_instr[5:0])))
        else value_error("offset6", $sampled(offset6), 16'($signed($sampled(exp_instr[5:0]))));

    a_offset9: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> offset9 == 16'($signed(exp_instr[8:0])) * 16'd2)
        else value_error("offset9", $sampled(offset9),
                         16'($signed($sampled(exp_instr[8:0]))) * 16'd2);

    a_offset11: assert property (@(posedge clk) disable iff (reset)
        exp_valid |-> offset11 == 16'($signed(exp_instr[10:0])) * 16'd2)
        else value_error("offset11", $sampled(offset11),
                         16'($signed($sampled(exp_instr[10:0]))) * 16'd2);

    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        (stall && !redirect) |=> $stable({dest, src1, src2, imm5, imm4, trapvect8, offset6,
                                          offset9, offset11, pc, ctrl_word, decode_valid}))
        else run_failure("decoded outputs changed while stall was high");

    initial
    begin
        lfsr_state     = 17'd80269;
        reset          = 1'b1;
        stall          = 1'b0;
        redirect       = 1'b0;
        redirect_pc    = 16'd0;
        delivered      = 0;
        zeros_seen     = 0;
        redirects_seen = 0;
        cycles         = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        while (delivered < NUM_INSTR)
        begin
            @(posedge clk);
            // Stall one cycle in four, redirect one cycle in thirty-two
            stall    <= (take_bits(2) == 16'd0);
            redirect <= (take_bits(5) == 16'd0);
            redirect_pc <= 16'h0100 + {9'd0, 6'(take_bits(6)), 1'b0};
            if (redirect)
                redirects_seen = redirects_seen + 1;
        end
        if (zeros_seen == 0)
            run_failure("no zero instruction reached the decoder");
        else if (redirects_seen == 0)
            run_failure("no redirect was issued");
        else
        begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule : tb_lc3b_frontend

`default_nettype wire

// ==== compile.f ====
logic/lc3b_isa_pkg.sv
logic/lc3b_ctrl_pkg.sv
logic/fetch_bundle_if.sv
logic/frontend_control.sv
logic/fetch_pc.sv
logic/control_rom.sv
logic/ifid_latch.sv
logic/lc3b_frontend.sv
verification/imem_model.sv
verification/tb_lc3b_frontend.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_lc3b_frontend
FILELIST = compile.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
